// File: src/pe_conv_cfg.svh
`ifndef PE_CONV_CFG_SVH
`define PE_CONV_CFG_SVH
`default_nettype none

// IF scratchpad ring whose depth is not a power of two
`define PE_IF_AW    4
`define PE_IF_DEPTH 12

// filter scratchpad holds all filters back to back
`define PE_FILT_AW  5

`define PE_DW       8           // IF and filter word width
`define PE_PSUM_W   20          // accumulator and psum width

`default_nettype wire
`endif

// File: src/pe_conv_pkg.sv
`include "pe_conv_cfg.svh"
`default_nettype none

package pe_conv_pkg;

        // scan settings held stable for a whole scan
        typedef struct packed {
                logic [`PE_IF_AW-1:0]   stride_len;
                logic [`PE_IF_AW-1:0]   if_start_pos;
                logic [`PE_FILT_AW-1:0] filter_len;
                logic                   if_end_valid;
                logic                   filt_ready;
                logic                   spare;          // reserved
        } scan_cfg_t;

        // write side pointers seen by the address generator
        typedef struct packed {
                logic [`PE_IF_AW-1:0]   if_waddr;
                logic [`PE_IF_AW-1:0]   if_end_pos;     // last valid IF word
                logic [`PE_FILT_AW-1:0] filt_waddr;
        } wr_state_t;

        typedef struct packed {
                logic [`PE_IF_AW-1:0]   if_raddr;
                logic [`PE_FILT_AW-1:0] filt_raddr;
                logic                   strobe;
        } rd_req_t;

        typedef struct packed {
                logic [`PE_PSUM_W-1:0]  value;
                logic                   valid;
        } psum_t;

endpackage

`default_nettype wire

// File: src/if_scratchpad.sv
`include "pe_conv_cfg.svh"
`default_nettype none

module if_scratchpad
        import pe_conv_pkg::*;
(
        input  wire                     clk,
        input  wire                     rst,
        input  wire                     clear,
        input  wire                     if_wr,
        input  wire [`PE_DW-1:0]        if_wdata,
        input  wire                     if_last,
        input  wire rd_req_t            rd,
        output logic [`PE_DW-1:0]       if_rdata,
        output logic [`PE_IF_AW-1:0]    if_waddr,
        output logic [`PE_IF_AW-1:0]    if_end_pos,
        output logic                    if_end_valid
);

        localparam logic [`PE_IF_AW-1:0] LAST_ADDR = `PE_IF_DEPTH - 1;

        logic [`PE_DW-1:0] mem [`PE_IF_DEPTH];

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        if_waddr     <= '0;
                        if_end_pos   <= '0;
                        if_end_valid <= 1'b0;
                end else if (clear) begin
                        if_waddr     <= '0;
                        if_end_pos   <= '0;
                        if_end_valid <= 1'b0;
                end else if (if_wr) begin
                        if_waddr <= (if_waddr == LAST_ADDR) ? '0 : if_waddr + 1'b1;   // ring wrap
                        if (if_last) begin
                                if_end_pos   <= if_waddr;
                                if_end_valid <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (if_wr)
                        mem[if_waddr] <= if_wdata;
                if (rd.strobe)
                        if_rdata <= mem[rd.if_raddr];   // data one cycle after strobe
        end

endmodule

`default_nettype wire

// File: src/filt_scratchpad.sv
`include "pe_conv_cfg.svh"
`default_nettype none

module filt_scratchpad
        import pe_conv_pkg::*;
(
        input  wire                     clk,
        input  wire                     rst,
        input  wire                     clear,
        input  wire                     filt_wr,
        input  wire [`PE_DW-1:0]        filt_wdata,
        input  wire                     filt_last,
        input  wire rd_req_t            rd,
        output logic [`PE_DW-1:0]       filt_rdata,
        output logic [`PE_FILT_AW-1:0]  filt_waddr,
        output logic                    filt_ready
);

        logic [`PE_DW-1:0] mem [2**`PE_FILT_AW];

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        filt_waddr <= '0;
                        filt_ready <= 1'b0;
                end else if (clear) begin
                        filt_waddr <= '0;
                        filt_ready <= 1'b0;
                end else if (filt_wr) begin
                        filt_waddr <= filt_waddr + 1'b1;
                        if (filt_last)
                                filt_ready <= 1'b1;     // all filters loaded
                end
        end

        always_ff @(posedge clk) begin
                if (filt_wr)
                        mem[filt_waddr] <= filt_wdata;
                if (rd.strobe)
                        filt_rdata <= mem[rd.filt_raddr];
        end

endmodule

`default_nettype wire

// File: src/read_addr_ctrl.sv
`default_nettype none

module read_addr_ctrl (
        input  wire     clk,
        input  wire     rst,
        input  wire     start,
        input  wire     psum_done,
        input  wire     stall,
        input  wire     filter_count_flag,
        input  wire     stride_count_flag,
        input  wire     filter_pos_flag,
        input  wire     read_safe,
        output logic    rd_en,
        output logic    filter_pos_ld,
        output logic    filter_pos_cnt_en,
        output logic    stride_pos_ld,
        output logic    stride_cnt_en,
        output logic    filter_count_cnt_en,
        output logic    scan_clear,
        output logic    full_done
);

        localparam logic [1:0] S_IDLE      = 2'd0;
        localparam logic [1:0] S_NEXT_FILT = 2'd1;
        localparam logic [1:0] S_NEXT_WIN  = 2'd2;
        localparam logic [1:0] S_READ      = 2'd3;

        logic [1:0] state;
        logic [1:0] next_state;
        logic       last_sent;          // last read of the window issued
        logic       win_done;

        assign win_done = filter_pos_flag & last_sent & psum_done;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        state     <= S_IDLE;
                        last_sent <= 1'b0;
                end else if (!stall) begin
                        state     <= next_state;
                        last_sent <= (state == S_READ) & ~win_done &
                                     (last_sent | (read_safe & filter_pos_flag));
                end
        end

        always_comb begin
                case (state)
                S_IDLE:      next_state = start ? S_NEXT_FILT : S_IDLE;
                S_NEXT_FILT: next_state = filter_count_flag ? S_IDLE : S_NEXT_WIN;
                S_NEXT_WIN:  next_state = stride_count_flag ? S_NEXT_FILT : S_READ;
                default:     next_state = win_done ? S_NEXT_WIN : S_READ;
                endcase
        end

        always_comb begin
                rd_en               = 1'b0;
                filter_pos_ld       = 1'b0;
                filter_pos_cnt_en   = 1'b0;
                stride_pos_ld       = 1'b0;
                stride_cnt_en       = 1'b0;
                filter_count_cnt_en = 1'b0;
                scan_clear          = 1'b0;
                full_done           = 1'b0;
                if (!stall) begin
                        case (state)
                        S_IDLE:
                                scan_clear = 1'b1;
                        S_NEXT_FILT: begin
                                stride_pos_ld = ~filter_count_flag;
                                full_done     = filter_count_flag;      // no filters left
                        end
                        S_NEXT_WIN: begin
                                filter_pos_ld       = 1'b1;
                                filter_count_cnt_en = stride_count_flag & ~filter_count_flag;
                        end
                        default: begin
                                rd_en             = read_safe & ~last_sent;
                                filter_pos_cnt_en = read_safe & ~filter_pos_flag;
                                stride_cnt_en     = win_done;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: src/read_addr_path.sv
`include "pe_conv_cfg.svh"
`default_nettype none

module read_addr_path
        import pe_conv_pkg::*;
(
        input  wire             clk,
        input  wire             rst,
        input  wire scan_cfg_t  cfg,
        input  wire wr_state_t  wr,
        input  wire             rd_en,
        input  wire             filter_pos_ld,
        input  wire             filter_pos_cnt_en,
        input  wire             stride_pos_ld,
        input  wire             stride_cnt_en,
        input  wire             filter_count_cnt_en,
        input  wire             scan_clear,
        output rd_req_t         rd,
        output logic            read_safe,
        output logic            stride_count_flag,
        output logic            filter_count_flag,
        output logic            filter_pos_flag
);

        localparam int IAW = `PE_IF_AW;
        localparam int FAW = `PE_FILT_AW;
        localparam int OW  = `PE_IF_AW + `PE_FILT_AW + 1;       // unwrapped window offsets

        logic [FAW-1:0]   filt_idx;
        logic [FAW-1:0]   filt_pos;
        logic [IAW-1:0]   win_idx;
        logic [OW-1:0]    win_base;
        logic [OW-1:0]    rd_off;
        logic [OW-1:0]    win_off;
        logic [IAW-1:0]   if_raddr;
        logic [IAW-1:0]   win_end;
        logic [2*FAW-1:0] filt_base;
        logic [FAW-1:0]   filt_raddr;

        // distance walked around the ring from one position to another
        function automatic logic [IAW-1:0] ring_dist(input logic [IAW-1:0] from,
                                                     input logic [IAW-1:0] to);
                if (to >= from)
                        return to - from;
                return IAW'(to + `PE_IF_DEPTH - from);
        endfunction

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        filt_idx <= '0;
                        filt_pos <= '0;
                        win_idx  <= '0;
                end else if (scan_clear) begin
                        filt_idx <= '0;
                        filt_pos <= '0;
                        win_idx  <= '0;
                end else begin
                        if (filter_count_cnt_en)
                                filt_idx <= filt_idx + 1'b1;
                        if (filter_pos_ld)
                                filt_pos <= '0;
                        else if (filter_pos_cnt_en)
                                filt_pos <= filt_pos + 1'b1;
                        if (stride_pos_ld)
                                win_idx <= '0;
                        else if (stride_cnt_en)
                                win_idx <= win_idx + 1'b1;
                end
        end

        assign win_base = OW'(win_idx * cfg.stride_len);
        assign rd_off   = win_base + OW'(filt_pos);
        assign win_off  = win_base + OW'(cfg.filter_len) - 1'b1;        // last word of window

        assign if_raddr = IAW'((OW'(cfg.if_start_pos) + rd_off) % `PE_IF_DEPTH);
        assign win_end  = IAW'((OW'(cfg.if_start_pos) + win_off) % `PE_IF_DEPTH);

        assign filt_base  = filt_idx * cfg.filter_len;
        assign filt_raddr = FAW'(filt_base + filt_pos);

        assign read_safe = (ring_dist(cfg.if_start_pos, wr.if_waddr) >
                            ring_dist(cfg.if_start_pos, if_raddr)) &
                           ((wr.filt_waddr > filt_raddr) | cfg.filt_ready);

        // an offset past one full ring cannot fit inside the valid input
        assign stride_count_flag = cfg.if_end_valid &
                                   ((win_off >= OW'(`PE_IF_DEPTH)) |
                                    (ring_dist(cfg.if_start_pos, win_end) >
                                     ring_dist(cfg.if_start_pos, wr.if_end_pos)));

        assign filter_count_flag = (filt_raddr == wr.filt_waddr) & cfg.filt_ready;
        assign filter_pos_flag   = (filt_pos == cfg.filter_len - 1'b1);

        assign rd = '{if_raddr: if_raddr, filt_raddr: filt_raddr, strobe: rd_en};

endmodule

`default_nettype wire

// File: src/mac_psum.sv
`include "pe_conv_cfg.svh"
`default_nettype none

module mac_psum
        import pe_conv_pkg::*;
(
        input  wire                     clk,
        input  wire                     rst,
        input  wire rd_req_t            rd,
        input  wire [`PE_DW-1:0]        if_rdata,
        input  wire [`PE_DW-1:0]        filt_rdata,
        input  wire                     filter_pos_flag,
        output psum_t                   psum,
        output logic                    psum_done
);

        logic                   data_vld;       // scratchpad data valid this cycle
        logic                   data_last;
        logic                   emit;
        logic [2*`PE_DW-1:0]    prod;
        logic [`PE_PSUM_W-1:0]  acc;
        logic [`PE_PSUM_W-1:0]  psum_value;
        logic                   psum_valid;

        assign prod = if_rdata * filt_rdata;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        data_vld   <= 1'b0;
                        data_last  <= 1'b0;
                        emit       <= 1'b0;
                        acc        <= '0;
                        psum_valid <= 1'b0;
                        psum_done  <= 1'b0;
                end else begin
                        data_vld   <= rd.strobe;
                        data_last  <= rd.strobe & filter_pos_flag;
                        emit       <= data_last;        // last product lands this cycle
                        psum_valid <= emit;
                        if (emit)
                                acc <= '0;
                        else if (data_vld)
                                acc <= acc + `PE_PSUM_W'(prod);
                        if (rd.strobe)
                                psum_done <= 1'b0;
                        else if (emit)
                                psum_done <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (emit)
                        psum_value <= acc;
        end

        assign psum = '{value: psum_value, valid: psum_valid};

endmodule

`default_nettype wire

// File: src/pe_conv_top.sv
`include "pe_conv_cfg.svh"
`default_nettype none

module pe_conv_top
        import pe_conv_pkg::*;
(
        input  wire                     clk,
        input  wire                     rst,
        input  wire                     clear,
        input  wire                     start,
        input  wire                     stall,
        input  wire [`PE_IF_AW-1:0]     stride_len,
        input  wire [`PE_IF_AW-1:0]     if_start_pos,
        input  wire [`PE_FILT_AW-1:0]   filter_len,
        input  wire                     if_wr,
        input  wire [`PE_DW-1:0]        if_wdata,
        input  wire                     if_last,
        input  wire                     filt_wr,
        input  wire [`PE_DW-1:0]        filt_wdata,
        input  wire                     filt_last,
        output psum_t                   psum,
        output logic                    full_done
);

        scan_cfg_t              cfg;
        wr_state_t              wr;
        rd_req_t                rd;
        logic [`PE_DW-1:0]      if_rdata;
        logic [`PE_DW-1:0]      filt_rdata;
        logic [`PE_IF_AW-1:0]   if_waddr;
        logic [`PE_IF_AW-1:0]   if_end_pos;
        logic                   if_end_valid;
        logic [`PE_FILT_AW-1:0] filt_waddr;
        logic                   filt_ready;
        logic                   psum_done;
        logic                   read_safe;
        logic                   rd_en;
        logic                   filter_pos_ld, filter_pos_cnt_en, filter_count_cnt_en;
        logic                   stride_pos_ld, stride_cnt_en, scan_clear;
        logic                   stride_count_flag, filter_count_flag, filter_pos_flag;

        assign cfg = '{stride_len: stride_len, if_start_pos: if_start_pos,
                       filter_len: filter_len, if_end_valid: if_end_valid,
                       filt_ready: filt_ready, spare: 1'b0};
        assign wr  = '{if_waddr: if_waddr, if_end_pos: if_end_pos, filt_waddr: filt_waddr};

        if_scratchpad u_if_spad (
                .clk, .rst, .clear, .if_wr, .if_wdata, .if_last, .rd,
                .if_rdata, .if_waddr, .if_end_pos, .if_end_valid
        );

        filt_scratchpad u_filt_spad (
                .clk, .rst, .clear, .filt_wr, .filt_wdata, .filt_last, .rd,
                .filt_rdata, .filt_waddr, .filt_ready
        );

        read_addr_ctrl u_ctrl (
                .clk, .rst, .start, .psum_done, .stall,
                .filter_count_flag, .stride_count_flag, .filter_pos_flag, .read_safe,
                .rd_en, .filter_pos_ld, .filter_pos_cnt_en, .stride_pos_ld, .stride_cnt_en,
                .filter_count_cnt_en, .scan_clear, .full_done
        );

        read_addr_path u_path (
                .clk, .rst, .cfg, .wr, .rd_en,
                .filter_pos_ld, .filter_pos_cnt_en, .stride_pos_ld, .stride_cnt_en,
                .filter_count_cnt_en,
                .scan_clear (scan_clear | clear),       // external clear also restarts the scan
                .rd, .read_safe, .stride_count_flag, .filter_count_flag, .filter_pos_flag
        );

        mac_psum u_mac (
                .clk, .rst, .rd, .if_rdata, .filt_rdata, .filter_pos_flag,
                .psum, .psum_done
        );

endmodule

`default_nettype wire

// File: tb/pe_conv_tb.sv
`include "pe_conv_cfg.svh"
`default_nettype none

module pe_conv_tb
        import pe_conv_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        logic                   clk, rst, clear, start, stall;
        logic [`PE_IF_AW-1:0]   stride_len, if_start_pos;
        logic [`PE_FILT_AW-1:0] filter_len;
        logic                   if_wr, if_last, filt_wr, filt_last;
        logic [`PE_DW-1:0]      if_wdata, filt_wdata;
        psum_t                  psum;
        logic                   full_done;

        int     vals[$];                // every number of the stim file in order
        int     exp_q[$];
        int     errors = 0;
        int     test_errors = 0;
        int     checked = 0;
        int     done_cnt = 0;
        int     cur_test = 0;
        int     cycles = 0;
        int     limit = 0;
        bit     counting = 0;
        int     seed = 32'h85bd;

        pe_conv_top uut (
                .clk, .rst, .clear, .start, .stall, .stride_len, .if_start_pos, .filter_len,
                .if_wr, .if_wdata, .if_last, .filt_wr, .filt_wdata, .filt_last,
                .psum, .full_done
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // scoreboard sampled on the rising edge
        always @(posedge clk) begin
                int exp_val;
                if (!rst && psum.valid) begin
                        assert (exp_q.size() != 0)
                        else begin
                                $display("test %0d: extra psum %h beyond the expected ones",
                                         cur_test, psum.value);
                                test_errors++;
                        end
                        if (exp_q.size() != 0) begin
                                exp_val = exp_q.pop_front();
                                checked++;
                                assert (psum.value == `PE_PSUM_W'(exp_val))
                                else begin
                                        $display("** Error psum.value exp=%h got=%h",
                                                 `PE_PSUM_W'(exp_val), psum.value);
                                        test_errors++;
                                end
                        end
                end
                if (!rst && full_done) begin
                        assert (exp_q.size() == 0)
                        else begin
                                $display("test %0d: full_done came before the last psum",
                                         cur_test);
                                test_errors++;
                        end
                        done_cnt++;
                end
        end

        always @(posedge clk) begin
                if (counting) begin
                        cycles++;
                        if (cycles > limit) begin
                                $display("timeout: run did not finish within %0d cycles", limit);
                                $display("Test failed");
                                $finish;
                        end
                end
        end

        task automatic load_stim();
                int fd;
                int code;
                int v;
                reg [8*160-1:0] line_buf;
                fd = $fopen("tb/pe_conv_stim.txt", "r");
                if (fd == 0)
                        return;
                while (!$feof(fd)) begin
                        code = $fscanf(fd, "%h", v);
                        if (code == 1)
                                vals.push_back(v);
                        else if (code < 0)
                                break;
                        else if ($fgets(line_buf, fd) == 0)     // skip a comment line
                                break;
                end
                $fclose(fd);
        endtask

        // cycle budget from words written and windows scanned
        task automatic set_limit(output int ntests);
                int pos;
                int flen, nfilt, nif, nexp;
                pos = 0;
                ntests = 0;
                limit = 0;
                while (pos + 8 <= vals.size()) begin
                        flen  = vals[pos + 2];
                        nfilt = vals[pos + 3];
                        nif   = vals[pos + 4];
                        nexp  = vals[pos + 7];
                        limit += (nif + nfilt * flen + nexp * (flen + 4)) * 4;
                        pos += 8 + nif + nfilt * flen + nexp;
                        ntests++;
                end
        endtask

        task automatic run_test(inout int pos);
                int stride, spos, flen, nfilt, nif, nfw, mode, stall_mode, nexp;
                int if_w[$];
                int f_w[$];
                int i, n_max;
                stride = vals[pos];
                spos = vals[pos + 1];
                flen = vals[pos + 2];
                nfilt = vals[pos + 3];
                nif = vals[pos + 4];
                mode = vals[pos + 5];
                stall_mode = vals[pos + 6];
                nexp = vals[pos + 7];
                nfw = nfilt * flen;
                pos += 8;
                for (i = 0; i < nif; i++)
                        if_w.push_back(vals[pos++]);
                for (i = 0; i < nfw; i++)
                        f_w.push_back(vals[pos++]);
                for (i = 0; i < nexp; i++)
                        exp_q.push_back(vals[pos++]);
                test_errors = 0;
                done_cnt = 0;
                clear = 1'b1;
                stride_len = stride;
                if_start_pos = spos;
                filter_len = flen;
                @(negedge clk);
                clear = 1'b0;
                if (mode != 0) begin
                        start = 1'b1;
                        @(negedge clk);
                        start = 1'b0;
                end
                n_max = (mode != 0) ? ((nif > nfw) ? nif : nfw) : nif + nfw;
                for (i = 0; i < n_max; i++) begin
                        if (mode != 0 && i < nfw || mode == 0 && i >= nif) begin
                                filt_wr = 1'b1;
                                filt_wdata = (mode != 0) ? f_w[i] : f_w[i - nif];
                                filt_last = (mode != 0) ? (i == nfw - 1) : (i == n_max - 1);
                        end
                        if (i < nif) begin
                                if_wr = 1'b1;
                                if_wdata = if_w[i];
                                if_last = (i == nif - 1);
                        end
                        @(negedge clk);
                        if_wr = 1'b0;
                        if_last = 1'b0;
                        filt_wr = 1'b0;
                        filt_last = 1'b0;
                        if (mode != 0)
                                repeat (3) @(negedge clk);      // slow writer
                end
                if (mode == 0) begin
                        start = 1'b1;
                        @(negedge clk);
                        start = 1'b0;
                end
                while (done_cnt == 0) begin
                        @(negedge clk);
                        stall = (stall_mode != 0) && (($random(seed) & 3) == 0);
                end
                stall = 1'b0;
                repeat (4) @(negedge clk);      // late or extra psums
                assert (exp_q.size() == 0)
                else begin
                        $display("test %0d: %0d expected psums never arrived",
                                 cur_test, exp_q.size());
                        test_errors++;
                end
                assert (done_cnt == 1)
                else begin
                        $display("test %0d: full_done pulsed %0d times instead of once",
                                 cur_test, done_cnt);
                        test_errors++;
                end
                exp_q.delete();
                errors += test_errors;
                $display("test %0d finished: %0d psums, %0d errors", cur_test, nexp, test_errors);
        endtask

        initial begin
                int ntests;
                int pos;
                rst = 1'b1;
                clear = 1'b0;
                start = 1'b0;
                stall = 1'b0;
                stride_len = '0;
                if_start_pos = '0;
                filter_len = '0;
                if_wr = 1'b0;
                if_wdata = '0;
                if_last = 1'b0;
                filt_wr = 1'b0;
                filt_wdata = '0;
                filt_last = 1'b0;
                load_stim();
                set_limit(ntests);
                if (ntests == 0) begin
                        $display("stimulus file is missing or holds no test");
                        errors++;
                end
                repeat (16) @(negedge clk);
                rst = 1'b0;
                counting = 1'b1;
                pos = 0;
                for (cur_test = 1; cur_test <= ntests; cur_test++)
                        run_test(pos);
                counting = 1'b0;
                $display("tests %0d, psums checked %0d, errors %0d", ntests, checked, errors);
                if (errors == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: pe_conv.f
+incdir+src
src/pe_conv_pkg.sv
src/if_scratchpad.sv
src/filt_scratchpad.sv
src/read_addr_ctrl.sv
src/read_addr_path.sv
src/mac_psum.sv
src/pe_conv_top.sv
tb/pe_conv_tb.sv

// File: tb/pe_conv_stim.txt
# header: stride start filter_len filters if_words mode stall expected_psums, all hex
# then one line each of IF words (padding first), filter words and expected psums
# mode 0 writes all data before start, mode 1 interleaves slow writes after start
# stride 1, one filter
1 0 3 1 6 0 0 4
1 2 3 4 5 6
1 2 3
e 14 1a 20
# stride 2, last window does not reach the end
2 0 3 1 8 0 0 3
1 2 3 4 5 6 7 8
2 1 1
7 f 17
# three filters
1 0 2 3 4 0 0 9
1 2 3 4
1 1 2 0 0 3
3 5 7 2 4 6 6 9 c
# slow interleaved writes after start
1 0 3 1 5 1 0 3
3 1 4 1 5
2 7 1
11 1f 14
# random stall, two filters, start 2
1 2 4 2 9 0 1 8
ff ff 1 2 3 4 5 6 7
1 0 2 1 1 1 1 1
b f 13 17 a e 12 16
# start 8, data wraps around the ring
3 8 4 1 12 0 0 3
ee ee ee ee ee ee ee ee 1 2 3 4 5 6 7 8 9 a
1 2 1 3
14 29 3e
